// ==== all.f ====
logic/region_pkg.sv
logic/fifobram_if.sv
logic/fifobram.sv
logic/region_exclusive.sv
logic/region_top.sv
sim/region_asserts.sv
sim/region_checker.sv
sim/region_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the region testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module region_tb -f all.f -o region_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can summarize
./obj_dir/region_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sim/region_tb.sv ====
`timescale 1ns/100ps

module region_tb;

    typedef logic [region_pkg::log2_depth-1:0] addr_t;
    typedef logic [region_pkg::width-1:0]      data_t;
    typedef logic [region_pkg::mode_w-1:0]     mode_t;

    localparam int n_addr = 48;
    localparam int n_fifo = 20;
    localparam int n_peek = 4;
    localparam int n_rand = 200;
    // one cycle per step, plus idle gaps and reset
    localparam int total_ops = n_addr + region_pkg::depth + 2 * n_fifo + 3 * n_peek + 4
                               + region_pkg::depth + n_rand + 30;

    logic  clk;
    logic  rst_n;
    logic  w_we, r0_re, r1_re;
    addr_t w_waddr, r0_raddr, r1_raddr;
    data_t w_wdata, r0_rdata, r1_rdata;
    mode_t w_wfifobram, r0_rfifobram, r1_rfifobram;
    logic  [region_pkg::log2_depth:0] w_count;
    logic  w_almostfull, r0_rvalid, r1_rvalid, r0_empty, r1_empty;

    region_top i_dut (.*);

    region_checker i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rch picks the read channel, -1 for none
    task automatic set_inputs(input logic we, input mode_t wm, input addr_t wa,
                              input data_t wd, input int rch, input mode_t rm,
                              input addr_t ra);
        w_we         = we;
        w_wfifobram  = wm;
        w_waddr      = wa;
        w_wdata      = wd;
        r0_re        = (rch == 0);
        r1_re        = (rch == 1);
        // the idle channel carries different fields
        r0_rfifobram = (rch == 0) ? rm : rm ^ mode_t'(1);
        r1_rfifobram = (rch == 1) ? rm : rm ^ mode_t'(1);
        r0_raddr     = (rch == 0) ? ra : ~ra;
        r1_raddr     = (rch == 1) ? ra : ~ra;
    endtask

    task automatic drive_cycle(input logic we, input mode_t wm, input addr_t wa,
                               input data_t wd, input int rch, input mode_t rm,
                               input addr_t ra);
        @(negedge clk);
        set_inputs(we, wm, wa, wd, rch, rm, ra);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, '0, -1, '0, '0);
    endtask

    task automatic push_word(input data_t d);
        drive_cycle(1'b1, region_pkg::mode_fifo, '0, d, -1, '0, '0);
    endtask

    task automatic read_word(input int rch, input mode_t rm, input addr_t ra);
        drive_cycle(1'b0, '0, '0, '0, rch, rm, ra);
    endtask

    initial begin
        int fails;
        mode_t wm;
        void'($urandom(32'he593_d37e));
        rst_n = 1'b0;
        set_inputs(1'b0, '0, '0, '0, -1, '0, '0);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // ********************
        // directed tests
        // ********************
        i_chk.begin_test("addressed_access");
        for (int i = 0; i < n_addr; i++) begin
            drive_cycle(1'b1, region_pkg::mode_addr,
                        (i < region_pkg::depth) ? addr_t'(i) : addr_t'($urandom),
                        data_t'($urandom), -1, '0, '0);
        end
        idle(2);
        for (int i = 0; i < region_pkg::depth; i++) begin
            read_word(i % 2, region_pkg::mode_addr, addr_t'(i));
        end
        idle(2);
        i_chk.end_test();

        i_chk.begin_test("fifo_order");
        for (int i = 0; i < n_fifo; i++) begin
            push_word(data_t'($urandom));
        end
        for (int i = 0; i < n_fifo; i++) begin
            read_word(int'($urandom_range(1, 0)), region_pkg::mode_fifo, '0);
        end
        idle(2);
        i_chk.end_test();

        i_chk.begin_test("peek");
        for (int i = 0; i < n_peek; i++) begin
            push_word(data_t'($urandom));
        end
        for (int i = 0; i < n_peek; i++) begin
            read_word(i % 2, region_pkg::mode_peek, '0);
            read_word(1 - i % 2, region_pkg::mode_fifo, '0);
        end
        idle(2);
        i_chk.end_test();

        i_chk.begin_test("empty_pop");
        read_word(0, region_pkg::mode_fifo, '0);
        read_word(1, region_pkg::mode_peek, '0);
        read_word(1, region_pkg::mode_fifo, '0);
        read_word(0, region_pkg::mode_peek, '0);
        idle(2);
        i_chk.end_test();

        i_chk.begin_test("almostfull_reset");
        for (int i = 0; i < region_pkg::depth - 2; i++) begin
            push_word(data_t'($urandom));
        end
        idle(2);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idle(2);
        i_chk.end_test();

        // ********************
        // random traffic
        // ********************
        i_chk.begin_test("channel_routing");
        for (int i = 0; i < n_rand; i++) begin
            wm = ($urandom_range(1, 0) == 0) ? region_pkg::mode_addr : region_pkg::mode_fifo;
            // up to three pushes can be ahead of the model count
            if (i_chk.cnt >= region_pkg::depth - 3) begin
                wm = region_pkg::mode_addr;
            end
            drive_cycle(1'($urandom), wm, addr_t'($urandom), data_t'($urandom),
                        int'($urandom_range(2, 0)) - 1, mode_t'($urandom_range(2, 0)),
                        addr_t'($urandom));
        end
        idle(2);
        i_chk.end_test();

        fails = i_chk.errors + i_dut.i_arb.i_asserts.fails;
        $display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 i_chk.tests, i_chk.failed_tests, i_chk.errors,
                 i_dut.i_arb.i_asserts.fails);
        if (fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(total_ops * 8 * 4);
        $display("timeout: tests did not finish within %0d ns", total_ops * 8 * 4);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== sim/region_checker.sv ====
`timescale 1ns/100ps

module region_checker (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              w_we,
    input logic [region_pkg::log2_depth-1:0] w_waddr,
    input logic [region_pkg::width-1:0]      w_wdata,
    input logic [region_pkg::mode_w-1:0]     w_wfifobram,
    input logic                              w_almostfull,
    input logic [region_pkg::log2_depth:0]   w_count,
    input logic                              r0_re, r1_re,
    input logic [region_pkg::log2_depth-1:0] r0_raddr, r1_raddr,
    input logic [region_pkg::mode_w-1:0]     r0_rfifobram, r1_rfifobram,
    input logic [region_pkg::width-1:0]      r0_rdata, r1_rdata,
    input logic                              r0_rvalid, r1_rvalid, r0_empty, r1_empty
);

    logic [region_pkg::width-1:0]      mem [region_pkg::depth];
    logic [region_pkg::log2_depth-1:0] head;
    logic [region_pkg::log2_depth-1:0] tail;
    int                                cnt;
    logic                              pend_we;
    logic [region_pkg::log2_depth-1:0] pend_addr;
    logic [region_pkg::width-1:0]      pend_data;
    logic [region_pkg::mode_w-1:0]     pend_mode;
    logic [1:0]                        exp_rv;
    logic [region_pkg::width-1:0]      exp_data;
    string                             test_name = "reset";
    int                                errors;
    int                                test_errors;
    int                                tests;
    int                                failed_tests;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            failed_tests++;
        end
    endtask

    // ********************
    // reference model
    // ********************
    always @(posedge clk or negedge rst_n) begin
        logic                              rd;
        logic [region_pkg::mode_w-1:0]     rd_mode;
        logic [region_pkg::log2_depth-1:0] rd_addr;
        logic                              push;
        logic                              pop;
        if (!rst_n) begin
            head    = '0;
            tail    = '0;
            cnt     = 0;
            pend_we = 1'b0;
            exp_rv  = '0;
        end else begin
            rd      = r0_re || r1_re;
            rd_mode = r0_re ? r0_rfifobram : r1_rfifobram;
            rd_addr = r0_re ? r0_raddr : r1_raddr;
            exp_rv  = '0;
            // head reads need a stored word
            if (rd && (rd_mode == region_pkg::mode_addr ||
                       ((rd_mode == region_pkg::mode_fifo || rd_mode == region_pkg::mode_peek)
                        && cnt != 0))) begin
                exp_rv   = r0_re ? 2'b01 : 2'b10;
                exp_data = (rd_mode == region_pkg::mode_addr) ? mem[rd_addr] : mem[head];
            end
            pop  = rd && rd_mode == region_pkg::mode_fifo && cnt != 0;
            push = pend_we && pend_mode == region_pkg::mode_fifo;
            // write sampled one edge ago lands after this edge's read
            if (pend_we && pend_mode == region_pkg::mode_addr) begin
                mem[pend_addr] = pend_data;
            end
            if (push) begin
                mem[tail] = pend_data;
                tail++;
            end
            if (pop) begin
                head++;
            end
            cnt       = cnt + int'(push) - int'(pop);
            pend_we   = w_we;
            pend_addr = w_waddr;
            pend_data = w_wdata;
            pend_mode = w_wfifobram;
        end
    end

    // ********************
    // compare
    // ********************
    always begin
        @(negedge clk);
        // outputs settle well before the next rising edge
        #2;
        check("r0_rvalid", 32'(exp_rv[0]), 32'(r0_rvalid));
        check("r1_rvalid", 32'(exp_rv[1]), 32'(r1_rvalid));
        if (exp_rv[0]) begin
            check("r0_rdata", 32'(exp_data), 32'(r0_rdata));
        end
        if (exp_rv[1]) begin
            check("r1_rdata", 32'(exp_data), 32'(r1_rdata));
        end
        check("count", 32'(cnt), 32'(w_count));
        check("r0_empty", 32'(cnt == 0), 32'(r0_empty));
        check("r1_empty", 32'(cnt == 0), 32'(r1_empty));
        check("almostfull", 32'(cnt >= region_pkg::depth - region_pkg::almost_margin),
              32'(w_almostfull));
    end

endmodule

// ==== sim/region_asserts.sv ====
`timescale 1ns/100ps

module region_asserts (
    input logic                                        clk,
    input logic                                        rst_n,
    input logic [region_pkg::num_read_channels-1:0]    rd_req,
    input logic [region_pkg::num_read_channels-1:0]    rd_grant,
    input logic [region_pkg::num_read_channels-1:0]    ch_rvalid,
    input logic                                        rvalid,
    input logic                                        empty,
    input logic [region_pkg::log2_depth:0]             count
);

    int fails = 0;

    // read channels must not ask in the same cycle
    single_read_req: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_req))
        else begin
            fails++;
            $error("more than one read channel requested in one cycle");
        end

    rvalid_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ch_rvalid))
        else begin
            fails++;
            $error("rvalid high on more than one read channel");
        end

    // a granted read with data available returns one cycle later
    rvalid_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
        (|rd_grant) && !empty |=> rvalid)
        else begin
            fails++;
            $error("granted read did not raise rvalid one cycle later");
        end

    rvalid_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> $past(|rd_grant))
        else begin
            fails++;
            $error("rvalid without a read grant in the previous cycle");
        end

    empty_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        count == '0 |-> empty)
        else begin
            fails++;
            $error("count is zero but empty is low");
        end

endmodule

bind region_exclusive region_asserts i_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req     ({rd_req[1], rd_req[0]}),
    .rd_grant   (rd_grant),
    .ch_rvalid  ({read_access[1].rvalid, read_access[0].rvalid}),
    .rvalid     (region.rvalid),
    .empty      (region.empty),
    .count      (region.count)
);

// ==== logic/region_top.sv ====
`timescale 1ns/100ps

module region_top (
    input  logic                              clk,
    input  logic                              rst_n,

    // write channel
    input  logic                              w_we,
    input  logic [region_pkg::log2_depth-1:0] w_waddr,
    input  logic [region_pkg::width-1:0]      w_wdata,
    input  logic [region_pkg::mode_w-1:0]     w_wfifobram,
    output logic                              w_almostfull,
    output logic [region_pkg::log2_depth:0]   w_count,

    // read channel 0
    input  logic                              r0_re,
    input  logic [region_pkg::log2_depth-1:0] r0_raddr,
    input  logic [region_pkg::mode_w-1:0]     r0_rfifobram,
    output logic [region_pkg::width-1:0]      r0_rdata,
    output logic                              r0_rvalid,
    output logic                              r0_empty,

    // read channel 1
    input  logic                              r1_re,
    input  logic [region_pkg::log2_depth-1:0] r1_raddr,
    input  logic [region_pkg::mode_w-1:0]     r1_rfifobram,
    output logic [region_pkg::width-1:0]      r1_rdata,
    output logic                              r1_rvalid,
    output logic                              r1_empty
);

    fifobram_if wr_ch [region_pkg::num_write_channels] ();
    fifobram_if rd_ch [region_pkg::num_read_channels] ();
    fifobram_if region ();

    assign wr_ch[0].we        = w_we;
    assign wr_ch[0].waddr     = w_waddr;
    assign wr_ch[0].wdata     = w_wdata;
    assign wr_ch[0].wfifobram = w_wfifobram;
    assign w_almostfull       = wr_ch[0].almostfull;
    assign w_count            = wr_ch[0].count;

    assign rd_ch[0].re        = r0_re;
    assign rd_ch[0].raddr     = r0_raddr;
    assign rd_ch[0].rfifobram = r0_rfifobram;
    assign r0_rdata           = rd_ch[0].rdata;
    assign r0_rvalid          = rd_ch[0].rvalid;
    assign r0_empty           = rd_ch[0].empty;

    assign rd_ch[1].re        = r1_re;
    assign rd_ch[1].raddr     = r1_raddr;
    assign rd_ch[1].rfifobram = r1_rfifobram;
    assign r1_rdata           = rd_ch[1].rdata;
    assign r1_rvalid          = rd_ch[1].rvalid;
    assign r1_empty           = rd_ch[1].empty;

    region_exclusive i_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_access (wr_ch),
        .read_access  (rd_ch),
        .region       (region)
    );

    fifobram i_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .access (region)
    );

endmodule

// ==== logic/region_exclusive.sv ====
`timescale 1ns/100ps

module region_exclusive (
    input logic clk,
    input logic rst_n,
    fifobram_if.write_source write_access [region_pkg::num_write_channels],
    fifobram_if.read_source  read_access [region_pkg::num_read_channels],
    fifobram_if.master       region
);

    localparam int nw = region_pkg::num_write_channels;
    localparam int nr = region_pkg::num_read_channels;

    // flattened channel requests
    logic                              wr_req [nw];
    logic [region_pkg::log2_depth-1:0] wr_req_addr [nw];
    logic [region_pkg::width-1:0]      wr_req_data [nw];
    logic [region_pkg::mode_w-1:0]     wr_req_mode [nw];
    logic                              rd_req [nr];
    logic [region_pkg::log2_depth-1:0] rd_req_addr [nr];
    logic [region_pkg::mode_w-1:0]     rd_req_mode [nr];

    logic                              wr_found;
    logic [region_pkg::log2_depth-1:0] wr_addr_sel;
    logic [region_pkg::width-1:0]      wr_data_sel;
    logic [region_pkg::mode_w-1:0]     wr_mode_sel;
    logic                              wr_we_q;
    logic [region_pkg::log2_depth-1:0] wr_addr_q;
    logic [region_pkg::width-1:0]      wr_data_q;
    logic [region_pkg::mode_w-1:0]     wr_mode_q;

    logic                              rd_found;
    logic [region_pkg::log2_depth-1:0] rd_addr_sel;
    logic [region_pkg::mode_w-1:0]     rd_mode_sel;
    logic [nr-1:0]                     rd_grant;
    logic [nr-1:0]                     rd_grant_q;

    // ********************
    // write channels
    // ********************
    for (genvar i = 0; i < nw; i++) begin : gen_write
        assign wr_req[i]      = write_access[i].we;
        assign wr_req_addr[i] = write_access[i].waddr;
        assign wr_req_data[i] = write_access[i].wdata;
        assign wr_req_mode[i] = write_access[i].wfifobram;
        assign write_access[i].almostfull = region.almostfull;
        assign write_access[i].count      = region.count;
    end

    // lowest index wins
    always_comb begin
        wr_found    = 1'b0;
        wr_addr_sel = '0;
        wr_data_sel = '0;
        wr_mode_sel = '0;
        for (int i = 0; i < nw; i++) begin
            if (wr_req[i] && !wr_found) begin
                wr_found    = 1'b1;
                wr_addr_sel = wr_req_addr[i];
                wr_data_sel = wr_req_data[i];
                wr_mode_sel = wr_req_mode[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_we_q <= 1'b0;
        end else begin
            wr_we_q <= wr_found;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_found) begin
            wr_addr_q <= wr_addr_sel;
            wr_data_q <= wr_data_sel;
            wr_mode_q <= wr_mode_sel;
        end
    end

    assign region.we        = wr_we_q;
    assign region.waddr     = wr_addr_q;
    assign region.wdata     = wr_data_q;
    assign region.wfifobram = wr_mode_q;

    // ********************
    // read channels
    // ********************
    for (genvar i = 0; i < nr; i++) begin : gen_read
        assign rd_req[i]      = read_access[i].re;
        assign rd_req_addr[i] = read_access[i].raddr;
        assign rd_req_mode[i] = read_access[i].rfifobram;
        // only the channel granted last cycle sees rvalid
        assign read_access[i].rvalid = region.rvalid && rd_grant_q[i];
        assign read_access[i].rdata  = region.rdata;
        assign read_access[i].empty  = region.empty;
    end

    always_comb begin
        rd_found    = 1'b0;
        rd_grant    = '0;
        rd_addr_sel = '0;
        rd_mode_sel = '0;
        for (int i = 0; i < nr; i++) begin
            if (rd_req[i] && !rd_found) begin
                rd_found    = 1'b1;
                rd_grant[i] = 1'b1;
                rd_addr_sel = rd_req_addr[i];
                rd_mode_sel = rd_req_mode[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_grant_q <= '0;
        end else begin
            rd_grant_q <= rd_grant;
        end
    end

    assign region.re        = rd_found;
    assign region.raddr     = rd_addr_sel;
    assign region.rfifobram = rd_mode_sel;

endmodule

// ==== logic/fifobram.sv ====
`timescale 1ns/100ps

module fifobram (
    input logic clk,
    input logic rst_n,
    fifobram_if.memory access
);

    logic [region_pkg::width-1:0]      mem [region_pkg::depth];
    logic [region_pkg::log2_depth-1:0] head;
    logic [region_pkg::log2_depth-1:0] tail;
    logic [region_pkg::log2_depth:0]   count;
    logic [region_pkg::width-1:0]      rdata_q;
    logic                              rvalid_q;
    logic                              fifo_empty;
    logic                              push;
    logic                              pop;
    logic                              rd_ok;

    assign fifo_empty = (count == '0);

    assign push = access.we && (access.wfifobram == region_pkg::mode_fifo);
    assign pop  = access.re && (access.rfifobram == region_pkg::mode_fifo) && !fifo_empty;

    // head-based reads need something in the fifo
    always_comb begin
        rd_ok = 1'b0;
        if (access.re) begin
            case (access.rfifobram)
                region_pkg::mode_addr: rd_ok = 1'b1;
                region_pkg::mode_fifo: rd_ok = !fifo_empty;
                region_pkg::mode_peek: rd_ok = !fifo_empty;
                default:               rd_ok = 1'b0;
            endcase
        end
    end

    // ********************
    // storage
    // ********************
    always_ff @(posedge clk) begin
        if (access.we) begin
            case (access.wfifobram)
                region_pkg::mode_addr: mem[access.waddr] <= access.wdata;
                region_pkg::mode_fifo: mem[tail] <= access.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ok) begin
            if (access.rfifobram == region_pkg::mode_addr) begin
                rdata_q <= mem[access.raddr];
            end else begin
                rdata_q <= mem[head];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_ok;
        end
    end

    // ********************
    // fifo pointers
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign access.rdata      = rdata_q;
    assign access.rvalid     = rvalid_q;
    assign access.empty      = fifo_empty;
    assign access.count      = count;
    assign access.almostfull = (count >= (region_pkg::log2_depth + 1)'(region_pkg::depth
                                           - region_pkg::almost_margin));

endmodule

// ==== logic/fifobram_if.sv ====
`timescale 1ns/100ps

interface fifobram_if;

    // write requests
    logic                                 we;
    logic [region_pkg::log2_depth-1:0]    waddr;
    logic [region_pkg::width-1:0]         wdata;
    logic [region_pkg::mode_w-1:0]        wfifobram;

    // read requests
    logic                                 re;
    logic [region_pkg::log2_depth-1:0]    raddr;
    logic [region_pkg::mode_w-1:0]        rfifobram;

    // returns and status
    logic [region_pkg::width-1:0]         rdata;
    logic                                 rvalid;
    logic                                 empty;
    logic                                 almostfull;
    logic [region_pkg::log2_depth:0]      count;

    // arbiter side of a write channel
    modport write_source (input we, waddr, wdata, wfifobram, output almostfull, count);

    // arbiter side of a read channel
    modport read_source (input re, raddr, rfifobram, output rdata, rvalid, empty);

    modport master (output we, waddr, wdata, wfifobram, re, raddr, rfifobram,
                    input rdata, rvalid, empty, almostfull, count);

    modport memory (input we, waddr, wdata, wfifobram, re, raddr, rfifobram,
                    output rdata, rvalid, empty, almostfull, count);

endinterface

// ==== logic/region_pkg.sv ====
package region_pkg;

    // ********************
    // memory geometry
    // ********************
    localparam int width = 8;
    localparam int log2_depth = 5;
    localparam int depth = 1 << log2_depth;

    // free entries left when almostfull rises
    localparam int almost_margin = 4;

    // ********************
    // channel counts
    // ********************
    localparam int num_write_channels = 1;
    localparam int num_read_channels = 2;

    // ********************
    // access modes
    // ********************
    localparam int mode_w = 2;
    localparam logic [mode_w-1:0] mode_addr = 2'd0;
    localparam logic [mode_w-1:0] mode_fifo = 2'd1;
    // reads only
    localparam logic [mode_w-1:0] mode_peek = 2'd2;

endpackage
